// File: build.f
+incdir+include
rtl/la_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/mini_la_core.sv
verification/core_properties.sv
verification/core_tb.sv

// File: include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and address width
`define CORE_XLEN 32

// integer registers, r0 reads as zero
`define CORE_NREGS 32

// first fetch address out of reset
`define CORE_RESET_PC 32'h1c00_0000

// byte strobe width on the sram and trace ports
`define CORE_WE_BITS 4

`endif

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  la_isa_pkg::word_t    id_pc,
    input  la_isa_pkg::insn_t    id_insn,
    input  logic                 id_valid,
    input  logic                 flush,
    input  la_isa_pkg::reg_idx_t ex_rd,
    input  logic                 ex_is_load,
    input  logic                 wb_en,
    input  la_isa_pkg::reg_idx_t wb_rd,
    input  la_isa_pkg::word_t    wb_data,
    output logic                 stall,
    output la_isa_pkg::word_t    ex_pc,
    output la_isa_pkg::reg_idx_t ex_rj,
    output la_isa_pkg::reg_idx_t ex_rk,
    output la_isa_pkg::reg_idx_t ex_rd_out,
    output la_isa_pkg::word_t    ex_opa,
    output la_isa_pkg::word_t    ex_opb,
    output la_isa_pkg::word_t    ex_imm,
    output la_isa_pkg::alu_op_e  ex_alu_op,
    output pipe_pkg::npc_op_e    ex_npc_op,
    output pipe_pkg::wb_sel_e    ex_wb_sel,
    output logic                 ex_use_imm,
    output logic                 ex_reg_we,
    output logic                 ex_mem_rd,
    output logic                 ex_mem_wr
);
    import la_isa_pkg::*;
    import pipe_pkg::*;

    word_t    rf [`CORE_NREGS]; // slot 0 never written
    reg_idx_t rj;
    reg_idx_t rk;
    reg_idx_t rd;
    reg_idx_t src2;             // rk, or rd for stores and branches
    reg_idx_t dest;
    word_t    imm;
    word_t    si12_ext;
    word_t    offs16_ext;
    word_t    offs26_ext;
    word_t    rdata1;
    word_t    rdata2;
    alu_op_e  alu_op;
    npc_op_e  npc_op;
    wb_sel_e  wb_sel;
    logic     use_imm;
    logic     reg_we;
    logic     mem_rd;
    logic     mem_wr;
    logic     use_rj;
    logic     use_src2;
    logic     src2_is_rd;
    logic     issue;

    assign rd = id_insn[4:0];
    assign rj = id_insn[9:5];
    assign rk = id_insn[14:10];

    assign si12_ext   = {{(`CORE_XLEN-12){id_insn[21]}}, id_insn[21:10]};
    assign offs16_ext = {{(`CORE_XLEN-18){id_insn[25]}}, id_insn[25:10], 2'b00};
    // offs26 is split, high part sits in insn[9:0]
    assign offs26_ext = {{(`CORE_XLEN-28){id_insn[9]}}, id_insn[9:0], id_insn[25:10], 2'b00};

    always_comb
    begin
        alu_op     = ALU_ADD;
        npc_op     = NPC_SEQ;
        wb_sel     = WB_ALU;
        imm        = si12_ext;
        dest       = rd;
        use_imm    = 1'b0;
        reg_we     = 1'b0;
        mem_rd     = 1'b0;
        mem_wr     = 1'b0;
        use_rj     = 1'b0;
        use_src2   = 1'b0;
        src2_is_rd = 1'b0;
        if (id_insn[31:15] inside {OP_ADD_W, OP_SUB_W, OP_AND, OP_OR, OP_SLT})
        begin
            reg_we   = 1'b1;
            use_rj   = 1'b1;
            use_src2 = 1'b1;
            case (id_insn[31:15])
                OP_SUB_W: alu_op = ALU_SUB;
                OP_AND:   alu_op = ALU_AND;
                OP_OR:    alu_op = ALU_OR;
                OP_SLT:   alu_op = ALU_SLT;
                default:  alu_op = ALU_ADD;
            endcase
        end
        else if (id_insn[31:22] inside {OP_ADDI_W, OP_LD_W})
        begin
            use_imm = 1'b1;
            use_rj  = 1'b1;
            reg_we  = 1'b1;
            mem_rd  = (id_insn[31:22] == OP_LD_W);
            wb_sel  = mem_rd ? WB_MEM : WB_ALU;
        end
        else if (id_insn[31:22] == OP_ST_W)
        begin
            use_imm    = 1'b1; // address = rj + si12
            use_rj     = 1'b1;
            use_src2   = 1'b1; // store data from rd
            src2_is_rd = 1'b1;
            mem_wr     = 1'b1;
        end
        else if (id_insn[31:25] == OP_LU12I_W)
        begin
            imm     = {id_insn[24:5], 12'h000};
            alu_op  = ALU_PASSB;
            use_imm = 1'b1;
            reg_we  = 1'b1;
        end
        else if (id_insn[31:26] inside {OP_BEQ, OP_BNE})
        begin
            imm        = offs16_ext;
            npc_op     = (id_insn[31:26] == OP_BEQ) ? NPC_BEQ : NPC_BNE;
            use_rj     = 1'b1;
            use_src2   = 1'b1;
            src2_is_rd = 1'b1; // compares rj with rd
        end
        else if (id_insn[31:26] inside {OP_B, OP_BL})
        begin
            imm    = offs26_ext;
            npc_op = NPC_JUMP;
            reg_we = (id_insn[31:26] == OP_BL);
            dest   = REG_RA;
            wb_sel = WB_LINK;
        end
    end

    assign src2 = src2_is_rd ? rd : rk;

    // r0 reads zero, same-cycle writeback wins over the array
    function automatic word_t rf_read(input reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (wb_en && wb_rd == idx)
            return wb_data;
        return rf[idx];
    endfunction

    always_comb
    begin
        rdata1 = rf_read(rj);
        rdata2 = rf_read(src2);
    end

    always_ff @(posedge clk)
    begin
        if (wb_en && wb_rd != '0)
            rf[wb_rd] <= wb_data;
    end

    // load in execute feeding a source here, wait one cycle
    assign stall = id_valid && ex_is_load && ex_rd != '0 &&
                   ((use_rj && rj == ex_rd) || (use_src2 && src2 == ex_rd));

    assign issue = id_valid && !flush && !stall; // else bubble into id/ex

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ex_reg_we <= 1'b0;
            ex_mem_rd <= 1'b0;
            ex_mem_wr <= 1'b0;
            ex_npc_op <= NPC_SEQ;
        end
        else
        begin
            ex_reg_we <= issue && reg_we && dest != '0; // r0 writes dropped here
            ex_mem_rd <= issue && mem_rd;
            ex_mem_wr <= issue && mem_wr;
            ex_npc_op <= issue ? npc_op : NPC_SEQ;
        end
    end

    always_ff @(posedge clk)
    begin
        ex_pc      <= id_pc;
        ex_rj      <= use_rj ? rj : '0;     // zero index never forwards
        ex_rk      <= use_src2 ? src2 : '0;
        ex_rd_out  <= dest;
        ex_opa     <= rdata1;
        ex_opb     <= rdata2;
        ex_imm     <= imm;
        ex_alu_op  <= alu_op;
        ex_wb_sel  <= wb_sel;
        ex_use_imm <= use_imm;
    end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module execute_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  la_isa_pkg::word_t    ex_pc,
    input  la_isa_pkg::reg_idx_t ex_rj,
    input  la_isa_pkg::reg_idx_t ex_rk,
    input  la_isa_pkg::reg_idx_t ex_rd_out,
    input  la_isa_pkg::word_t    ex_opa,
    input  la_isa_pkg::word_t    ex_opb,
    input  la_isa_pkg::word_t    ex_imm,
    input  la_isa_pkg::alu_op_e  ex_alu_op,
    input  pipe_pkg::npc_op_e    ex_npc_op,
    input  pipe_pkg::wb_sel_e    ex_wb_sel,
    input  logic                 ex_use_imm,
    input  logic                 ex_reg_we,
    input  logic                 ex_mem_rd,
    input  logic                 ex_mem_wr,
    input  la_isa_pkg::reg_idx_t mem_rd,
    input  la_isa_pkg::word_t    mem_data,
    input  la_isa_pkg::reg_idx_t wb_rd,
    input  logic                 wb_en,
    input  la_isa_pkg::word_t    wb_data,
    output logic                 redirect,
    output la_isa_pkg::word_t    redirect_pc,
    output logic                 data_sram_en,
    output la_isa_pkg::be_t      data_sram_we,
    output la_isa_pkg::word_t    data_sram_addr,
    output la_isa_pkg::word_t    data_sram_wdata,
    output la_isa_pkg::word_t    m_pc,
    output la_isa_pkg::reg_idx_t m_rd,
    output la_isa_pkg::word_t    m_result,
    output logic                 m_reg_we,
    output logic                 m_is_load,
    output pipe_pkg::wb_sel_e    m_wb_sel,
    output la_isa_pkg::reg_idx_t ex_rd,
    output logic                 ex_is_load
);
    import la_isa_pkg::*;
    import pipe_pkg::*;

    fwd_sel_e sel_a;
    fwd_sel_e sel_b;
    word_t    op_a;   // rj after forwarding
    word_t    op_k;   // rk or rd after forwarding
    word_t    alu_b;
    word_t    alu_res;
    logic     taken;

    // mem_rd is zero unless that stage writes a register
    function automatic fwd_sel_e fwd_src(input reg_idx_t idx);
        if (idx == '0)
            return FWD_RF;
        if (idx == mem_rd)
            return FWD_MEM; // youngest producer first
        if (wb_en && idx == wb_rd)
            return FWD_WB;
        return FWD_RF;
    endfunction

    function automatic word_t fwd_val(input fwd_sel_e sel, input word_t rf_val);
        case (sel)
            FWD_MEM: return mem_data;
            FWD_WB:  return wb_data;
            default: return rf_val;
        endcase
    endfunction

    always_comb
    begin
        sel_a = fwd_src(ex_rj);
        sel_b = fwd_src(ex_rk);
        op_a  = fwd_val(sel_a, ex_opa);
        op_k  = fwd_val(sel_b, ex_opb);
    end

    assign alu_b = ex_use_imm ? ex_imm : op_k;

    always_comb
    begin
        case (ex_alu_op)
            ALU_SUB:   alu_res = op_a - alu_b;
            ALU_AND:   alu_res = op_a & alu_b;
            ALU_OR:    alu_res = op_a | alu_b;
            ALU_SLT:   alu_res = word_t'($signed(op_a) < $signed(alu_b));
            ALU_PASSB: alu_res = alu_b;
            default:   alu_res = op_a + alu_b; // add, addresses
        endcase
    end

    // branch compare uses rj against rd, never the immediate
    always_comb
    begin
        case (ex_npc_op)
            NPC_BEQ:  taken = (op_a == op_k);
            NPC_BNE:  taken = (op_a != op_k);
            NPC_JUMP: taken = 1'b1;
            default:  taken = 1'b0;
        endcase
    end

    assign redirect    = taken; // flushes if/id and id/ex
    assign redirect_pc = ex_pc + ex_imm;

    assign data_sram_en    = ex_mem_rd || ex_mem_wr;
    assign data_sram_we    = {`CORE_WE_BITS{ex_mem_wr}}; // word stores only
    assign data_sram_addr  = alu_res;
    assign data_sram_wdata = op_k;

    // hazard view for decode
    assign ex_rd      = ex_rd_out;
    assign ex_is_load = ex_mem_rd;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            m_reg_we  <= 1'b0;
            m_is_load <= 1'b0;
            m_wb_sel  <= WB_ALU;
        end
        else
        begin
            m_reg_we  <= ex_reg_we;
            m_is_load <= ex_mem_rd;
            m_wb_sel  <= ex_wb_sel;
        end
    end

    always_ff @(posedge clk)
    begin
        m_pc     <= ex_pc;
        m_rd     <= ex_rd_out;
        m_result <= alu_res;
    end

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module fetch_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              redirect,
    input  la_isa_pkg::word_t redirect_pc,
    output la_isa_pkg::word_t inst_sram_addr,
    input  la_isa_pkg::insn_t inst_sram_rdata,
    output la_isa_pkg::word_t id_pc,
    output la_isa_pkg::insn_t id_insn,
    output logic              id_valid
);
    import la_isa_pkg::*;

    word_t pc_q;     // address of the word returning this cycle
    word_t npc;
    logic  fetch_on; // first cycle after reset has no word yet

    always_comb
    begin
        if (redirect)
            npc = redirect_pc;    // branch target from execute
        else if (stall)
            npc = pc_q;           // read same word again
        else
            npc = pc_q + word_t'(4);
    end

    assign inst_sram_addr = npc; // sram answers next edge

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc_q     <= `CORE_RESET_PC - word_t'(4); // npc starts at reset pc
            fetch_on <= 1'b0;
            id_valid <= 1'b0;
        end
        else
        begin
            pc_q     <= npc;
            fetch_on <= 1'b1;
            if (redirect)
                id_valid <= 1'b0; // wrong-path slot becomes bubble
            else if (!stall)
                id_valid <= fetch_on;
        end
    end

    // if/id payload, frozen during stall
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            id_pc   <= pc_q;
            id_insn <= inst_sram_rdata;
        end
    end

endmodule

// File: rtl/la_isa_pkg.sv
`include "core_settings.svh"

package la_isa_pkg;

    typedef logic [`CORE_XLEN-1:0]    word_t;    // data word or byte address
    typedef logic [31:0]              insn_t;    // fixed 32-bit encoding
    typedef logic [4:0]               reg_idx_t; // rd / rj / rk field
    typedef logic [`CORE_WE_BITS-1:0] be_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,   // signed compare
        ALU_PASSB  // lu12i.w, immediate straight through
    } alu_op_e;

    // 3R format, opcode in insn[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;

    // 2RI12 format, insn[31:22]
    localparam logic [9:0]  OP_ADDI_W = 10'h00a;
    localparam logic [9:0]  OP_LD_W   = 10'h0a2;
    localparam logic [9:0]  OP_ST_W   = 10'h0a6;

    localparam logic [6:0]  OP_LU12I_W = 7'h0a; // 1RI20, insn[31:25]

    // branch and jump, insn[31:26]
    localparam logic [5:0]  OP_B   = 6'h14;
    localparam logic [5:0]  OP_BL  = 6'h15;
    localparam logic [5:0]  OP_BEQ = 6'h16;
    localparam logic [5:0]  OP_BNE = 6'h17;

    localparam reg_idx_t REG_RA = 5'd1; // bl link register

endpackage

// File: rtl/mem_wb_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module mem_wb_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  la_isa_pkg::word_t    m_pc,
    input  la_isa_pkg::reg_idx_t m_rd,
    input  la_isa_pkg::word_t    m_result,
    input  logic                 m_reg_we,
    input  logic                 m_is_load,
    input  pipe_pkg::wb_sel_e    m_wb_sel,
    input  la_isa_pkg::word_t    data_sram_rdata,
    output la_isa_pkg::reg_idx_t mem_rd,
    output la_isa_pkg::word_t    mem_data,
    output logic                 wb_en,
    output la_isa_pkg::reg_idx_t wb_rd,
    output la_isa_pkg::word_t    wb_data,
    output la_isa_pkg::word_t    debug_wb_pc,
    output la_isa_pkg::be_t      debug_wb_rf_we,
    output la_isa_pkg::reg_idx_t debug_wb_rf_wnum,
    output la_isa_pkg::word_t    debug_wb_rf_wdata
);
    import la_isa_pkg::*;
    import pipe_pkg::*;

    word_t    w_pc;
    reg_idx_t w_rd;
    word_t    w_value;  // alu result or link address
    word_t    w_load;   // sram word, loads only
    logic     w_reg_we;
    wb_sel_e  w_wb_sel;

    // forward source for execute; load data not ready here, decode stalls
    assign mem_rd   = m_reg_we ? m_rd : '0;
    assign mem_data = (m_wb_sel == WB_LINK) ? m_pc + word_t'(4) : m_result;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            w_reg_we <= 1'b0;
            w_wb_sel <= WB_ALU;
        end
        else
        begin
            w_reg_we <= m_reg_we;
            w_wb_sel <= m_wb_sel;
        end
    end

    always_ff @(posedge clk)
    begin
        w_pc    <= m_pc;
        w_rd    <= m_rd;
        w_value <= mem_data;
        if (m_is_load)
            w_load <= data_sram_rdata; // read issued in execute
    end

    assign wb_en   = w_reg_we;
    assign wb_rd   = w_rd;
    assign wb_data = (w_wb_sel == WB_MEM) ? w_load : w_value;

    // trace mirrors the register file write port
    assign debug_wb_pc       = w_pc;
    assign debug_wb_rf_we    = {`CORE_WE_BITS{w_reg_we}};
    assign debug_wb_rf_wnum  = w_rd;
    assign debug_wb_rf_wdata = wb_data;

endmodule

// File: rtl/mini_la_core.sv
`timescale 1ns/1ps

module mini_la_core (
    input  logic                 clk,
    input  logic                 rst_n,
    output la_isa_pkg::word_t    inst_sram_addr,
    input  la_isa_pkg::insn_t    inst_sram_rdata,
    output logic                 data_sram_en,
    output la_isa_pkg::be_t      data_sram_we,
    output la_isa_pkg::word_t    data_sram_addr,
    output la_isa_pkg::word_t    data_sram_wdata,
    input  la_isa_pkg::word_t    data_sram_rdata,
    output la_isa_pkg::word_t    debug_wb_pc,
    output la_isa_pkg::be_t      debug_wb_rf_we,
    output la_isa_pkg::reg_idx_t debug_wb_rf_wnum,
    output la_isa_pkg::word_t    debug_wb_rf_wdata
);
    import la_isa_pkg::*;
    import pipe_pkg::*;

    // fetch <-> decode, redirect from execute
    logic     stall;
    logic     redirect;
    word_t    redirect_pc;
    word_t    id_pc;
    insn_t    id_insn;
    logic     id_valid;

    // id/ex
    word_t    ex_pc;
    reg_idx_t ex_rj;
    reg_idx_t ex_rk;
    reg_idx_t ex_rd_out;
    word_t    ex_opa;
    word_t    ex_opb;
    word_t    ex_imm;
    alu_op_e  ex_alu_op;
    npc_op_e  ex_npc_op;
    wb_sel_e  ex_wb_sel;
    logic     ex_use_imm;
    logic     ex_reg_we;
    logic     ex_mem_rd;
    logic     ex_mem_wr;
    reg_idx_t ex_rd;      // hazard check
    logic     ex_is_load;

    // ex/mem
    word_t    m_pc;
    reg_idx_t m_rd;
    word_t    m_result;
    logic     m_reg_we;
    logic     m_is_load;
    wb_sel_e  m_wb_sel;

    // forwarding and register write
    reg_idx_t mem_rd;
    word_t    mem_data;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    fetch_stage fetch_stage_i (.*);

    decode_stage decode_stage_i (
        .flush (redirect),
        .*
    );

    execute_stage execute_stage_i (.*);

    mem_wb_stage mem_wb_stage_i (.*);

endmodule

// File: rtl/pipe_pkg.sv
package pipe_pkg;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_RF,   // value read in decode
        FWD_MEM,  // producer one ahead
        FWD_WB    // producer two ahead
    } fwd_sel_e;

    // register write source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK   // pc + 4
    } wb_sel_e;

    // next pc operation, resolved in execute
    typedef enum logic [1:0] {
        NPC_SEQ,
        NPC_BEQ,
        NPC_BNE,
        NPC_JUMP  // b and bl
    } npc_op_e;

endpackage

// File: verification/core_properties.sv
`timescale 1ns/1ps

module core_properties (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 data_sram_en,
    input la_isa_pkg::be_t      data_sram_we,
    input la_isa_pkg::be_t      debug_wb_rf_we,
    input la_isa_pkg::reg_idx_t debug_wb_rf_wnum
);
    import la_isa_pkg::*;

    int unsigned fail_count = 0; // failed assertions so far

    // a store strobe only with the sram enabled
    we_has_en: assert property (@(posedge clk) disable iff (!rst_n)
        data_sram_we != '0 |-> data_sram_en)
        else
        begin
            $error("data_sram_we set while data_sram_en is low");
            fail_count++;
        end

    // trace quiet in the first cycle out of reset
    trace_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> debug_wb_rf_we == '0)
        else
        begin
            $error("debug_wb_rf_we active right after reset");
            fail_count++;
        end

    // r0 writes never reach writeback
    no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        debug_wb_rf_we != '0 |-> debug_wb_rf_wnum != '0)
        else
        begin
            $error("trace write names r0");
            fail_count++;
        end

    // word stores only
    we_all_or_none: assert property (@(posedge clk) disable iff (!rst_n)
        data_sram_we == '0 || data_sram_we == be_t'('1))
        else
        begin
            $error("data_sram_we is a partial strobe");
            fail_count++;
        end

endmodule

bind mini_la_core core_properties core_properties_i (.*);

// File: verification/core_tb.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_tb;
    import la_isa_pkg::*;

    localparam int RESET_CYCLES  = 8;
    localparam int IMEM_WORDS    = 64;
    localparam int DMEM_WORDS    = 256;  // 1 KiB at address 0
    localparam int SETTLE_CYCLES = 12;   // quiet tail after last commit

    // LoongArch32 major opcodes
    localparam logic [16:0] OPC_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_SLT     = 17'h00024;
    localparam logic [16:0] OPC_AND     = 17'h00029;
    localparam logic [16:0] OPC_OR      = 17'h0002a;
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;
    localparam logic [9:0]  OPC_LD_W    = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W    = 10'h0a6;
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;
    localparam logic [5:0]  OPC_B       = 6'h14;
    localparam logic [5:0]  OPC_BL      = 6'h15;
    localparam logic [5:0]  OPC_BEQ     = 6'h16;
    localparam logic [5:0]  OPC_BNE     = 6'h17;

    logic     clk;
    logic     rst_n;
    word_t    inst_sram_addr;
    insn_t    inst_sram_rdata;
    logic     data_sram_en;
    be_t      data_sram_we;
    word_t    data_sram_addr;
    word_t    data_sram_wdata;
    word_t    data_sram_rdata;
    word_t    debug_wb_pc;
    be_t      debug_wb_rf_we;
    reg_idx_t debug_wb_rf_wnum;
    word_t    debug_wb_rf_wdata;

    insn_t    imem [IMEM_WORDS];
    word_t    dmem [DMEM_WORDS];

    word_t    prog_pc [$];      // program table
    insn_t    prog_insn [$];
    bit       prog_shadow [$];  // 1 for words a taken branch must discard
    word_t    exp_pc [$];       // commits in program order
    reg_idx_t exp_reg [$];
    word_t    exp_val [$];
    word_t    st_addr [$];      // stores in program order
    word_t    st_data [$];
    int       st_seen;
    bit       tables_built;

    mini_la_core mini_la_core_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            abort_run($sformatf("FAILED time %0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp)
            abort_run($sformatf("FAILED time %0t %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic check_be(input string name, input be_t got, input be_t exp);
        if (got !== exp)
            abort_run($sformatf("FAILED time %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    // instruction encoders in ISA manual field order
    function automatic insn_t asm_3r(input logic [16:0] op, input reg_idx_t rd,
                                     input reg_idx_t rj, input reg_idx_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic insn_t asm_2ri12(input logic [9:0] op, input reg_idx_t rd,
                                        input reg_idx_t rj, input logic [11:0] si12);
        return {op, si12, rj, rd};
    endfunction

    function automatic insn_t asm_lu12i(input reg_idx_t rd, input logic [19:0] si20);
        return {OPC_LU12I_W, si20, rd};
    endfunction

    // offsets in words; beq/bne compare rj with rd
    function automatic insn_t asm_br(input logic [5:0] op, input reg_idx_t rj,
                                     input reg_idx_t rd, input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic insn_t asm_jump(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]}; // high half lands in [9:0]
    endfunction

    // initial data memory contents unique per byte address
    function automatic word_t fill_word(input word_t addr);
        return addr ^ 32'h5ca1_ab1e;
    endfunction

    function automatic insn_t imem_word(input word_t addr);
        word_t off;
        off = addr - `CORE_RESET_PC;
        if (off < IMEM_WORDS * 4)
            return imem[off[31:2]];
        return '0; // no-op outside the program
    endfunction

    function automatic bit is_discarded(input word_t pc);
        foreach (prog_pc[k])
            if (prog_pc[k] == pc)
                return prog_shadow[k];
        return 1'b0;
    endfunction

    task automatic emit(input insn_t insn, input bit shadow);
        prog_pc.push_back(`CORE_RESET_PC + word_t'(4 * prog_pc.size()));
        prog_insn.push_back(insn);
        prog_shadow.push_back(shadow);
    endtask

    task automatic expect_commit(input insn_t insn, input reg_idx_t rd, input word_t value);
        emit(insn, 1'b0);
        exp_pc.push_back(prog_pc[$]);
        exp_reg.push_back(rd);
        exp_val.push_back(value);
    endtask

    task automatic expect_store(input insn_t insn, input word_t addr, input word_t data);
        emit(insn, 1'b0);
        st_addr.push_back(addr);
        st_data.push_back(data);
    endtask

    task automatic build_program();
        // independent alu and immediate ops
        expect_commit(asm_lu12i(5'd4, 20'h12345), 5'd4, 32'h1234_5000);
        expect_commit(asm_2ri12(OPC_ADDI_W, 5'd5, 5'd0, 12'h678), 5'd5, 32'h0000_0678);
        expect_commit(asm_2ri12(OPC_ADDI_W, 5'd6, 5'd0, 12'hffd), 5'd6, 32'hffff_fffd); // -3
        expect_commit(asm_2ri12(OPC_ADDI_W, 5'd7, 5'd0, 12'h0f0), 5'd7, 32'h0000_00f0);
        expect_commit(asm_3r(OPC_ADD_W, 5'd8, 5'd4, 5'd5), 5'd8, 32'h1234_5678);
        expect_commit(asm_3r(OPC_SUB_W, 5'd9, 5'd5, 5'd7), 5'd9, 32'h0000_0588);
        expect_commit(asm_3r(OPC_AND, 5'd10, 5'd5, 5'd7), 5'd10, 32'h0000_0070);
        expect_commit(asm_3r(OPC_OR, 5'd11, 5'd4, 5'd7), 5'd11, 32'h1234_50f0);
        expect_commit(asm_3r(OPC_SLT, 5'd12, 5'd6, 5'd5), 5'd12, 32'd1); // signed compare
        expect_commit(asm_3r(OPC_SLT, 5'd13, 5'd5, 5'd6), 5'd13, 32'd0);
        // dependents at distance 1 and 2
        expect_commit(asm_2ri12(OPC_ADDI_W, 5'd14, 5'd0, 12'h100), 5'd14, 32'h0000_0100);
        expect_commit(asm_3r(OPC_ADD_W, 5'd15, 5'd14, 5'd14), 5'd15, 32'h0000_0200);
        expect_commit(asm_3r(OPC_SUB_W, 5'd16, 5'd15, 5'd14), 5'd16, 32'h0000_0100);
        expect_commit(asm_2ri12(OPC_ADDI_W, 5'd17, 5'd15, 12'h005), 5'd17, 32'h0000_0205);
        // store, read back, then load-use pairs
        expect_commit(asm_2ri12(OPC_ADDI_W, 5'd18, 5'd0, 12'h040), 5'd18, 32'h0000_0040);
        expect_store(asm_2ri12(OPC_ST_W, 5'd8, 5'd18, 12'h000), 32'h40, 32'h1234_5678);
        expect_commit(asm_2ri12(OPC_LD_W, 5'd19, 5'd18, 12'h000), 5'd19, 32'h1234_5678);
        expect_commit(asm_3r(OPC_ADD_W, 5'd20, 5'd19, 5'd5), 5'd20, 32'h1234_5cf0);
        expect_commit(asm_2ri12(OPC_LD_W, 5'd21, 5'd0, 12'h080), 5'd21, fill_word(32'h80));
        expect_commit(asm_2ri12(OPC_ADDI_W, 5'd22, 5'd21, 12'h001), 5'd22,
                      fill_word(32'h80) + 32'd1);
        emit(asm_br(OPC_BNE, 5'd5, 5'd5, 16'd3), 1'b0);                 // falls through
        expect_commit(asm_2ri12(OPC_ADDI_W, 5'd23, 5'd0, 12'h7ff), 5'd23, 32'h0000_07ff);
        emit(asm_br(OPC_BEQ, 5'd14, 5'd16, 16'd3), 1'b0);               // 0x100 == 0x100
        emit(asm_2ri12(OPC_ADDI_W, 5'd24, 5'd0, 12'h001), 1'b1);
        emit(asm_2ri12(OPC_ST_W, 5'd5, 5'd0, 12'h020), 1'b1);
        expect_commit(asm_2ri12(OPC_ADDI_W, 5'd25, 5'd0, 12'h055), 5'd25, 32'h0000_0055);
        emit(asm_jump(OPC_B, 26'd3), 1'b0);
        emit(asm_2ri12(OPC_ADDI_W, 5'd26, 5'd0, 12'h002), 1'b1);
        emit(asm_2ri12(OPC_ST_W, 5'd5, 5'd0, 12'h024), 1'b1);
        expect_commit(asm_jump(OPC_BL, 26'd3), 5'd1, `CORE_RESET_PC + 32'h78); // own pc + 4
        emit(asm_2ri12(OPC_ADDI_W, 5'd27, 5'd0, 12'h003), 1'b1);
        emit(asm_2ri12(OPC_ADDI_W, 5'd28, 5'd0, 12'h004), 1'b1);
        expect_commit(asm_3r(OPC_ADD_W, 5'd29, 5'd1, 5'd25), 5'd29, `CORE_RESET_PC + 32'hcd);
        expect_store(asm_2ri12(OPC_ST_W, 5'd29, 5'd0, 12'h044), 32'h44, `CORE_RESET_PC + 32'hcd);
        expect_commit(asm_2ri12(OPC_LD_W, 5'd30, 5'd0, 12'h044), 5'd30, `CORE_RESET_PC + 32'hcd);
        expect_commit(asm_2ri12(OPC_ADDI_W, 5'd31, 5'd30, 12'h000), 5'd31,
                      `CORE_RESET_PC + 32'hcd);
        emit(asm_2ri12(OPC_ADDI_W, 5'd0, 5'd0, 12'h123), 1'b0);         // r0 stays zero
        expect_commit(asm_2ri12(OPC_ADDI_W, 5'd3, 5'd0, 12'h009), 5'd3, 32'h0000_0009);
    endtask

    // instruction sram with one clock read latency
    always @(posedge clk)
    begin
        inst_sram_rdata <= imem_word(inst_sram_addr);
    end

    // data sram writes or reads per strobe
    always @(posedge clk)
    begin
        if (data_sram_en)
        begin
            if (data_sram_addr >= word_t'(DMEM_WORDS * 4))
                abort_run($sformatf("data access at %h is outside the data memory",
                                    data_sram_addr));
            else if (data_sram_we != '0)
                dmem[data_sram_addr[9:2]] <= data_sram_wdata;
            else
                data_sram_rdata <= dmem[data_sram_addr[9:2]];
        end
    end

    // every strobe cycle is one store
    always @(negedge clk)
    begin
        if (rst_n && data_sram_we != '0)
        begin
            if (st_seen >= st_addr.size())
                abort_run($sformatf("unexpected store to %h", data_sram_addr));
            else
            begin
                check_be("data_sram_we", data_sram_we, be_t'('1));
                check_word("data_sram_addr", data_sram_addr, st_addr[st_seen]);
                check_word("data_sram_wdata", data_sram_wdata, st_data[st_seen]);
                st_seen = st_seen + 1;
            end
        end
    end

    // property checker failure count
    always @(mini_la_core_i.core_properties_i.fail_count)
    begin
        if (mini_la_core_i.core_properties_i.fail_count != 0)
            abort_run("a concurrent assertion on the core ports failed");
    end

    initial
    begin
        int limit;
        wait (tables_built);
        limit = RESET_CYCLES + prog_pc.size() * 10;
        repeat (limit) @(posedge clk);
        abort_run($sformatf("run timed out after %0d cycles with commits or stores pending",
                            limit));
    end

    initial
    begin
        int i;
        rst_n           = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        st_seen         = 0;
        build_program();
        foreach (imem[k])
            imem[k] = '0;
        foreach (prog_pc[k])
            imem[(prog_pc[k] - `CORE_RESET_PC) >> 2] = prog_insn[k];
        foreach (dmem[k])
            dmem[k] = fill_word(word_t'(k * 4));
        tables_built = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (i = 0; i < exp_pc.size(); i++)
        begin
            do
            begin
                @(negedge clk);
            end
            while (debug_wb_rf_we == '0);
            if (is_discarded(debug_wb_pc))
                abort_run($sformatf("unexpected writeback from discarded instruction at pc %h",
                                    debug_wb_pc));
            check_be("debug_wb_rf_we", debug_wb_rf_we, be_t'('1));
            check_word("debug_wb_pc", debug_wb_pc, exp_pc[i]);
            check_reg("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_reg[i]);
            check_word("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val[i]);
        end

        // nothing else may commit
        repeat (SETTLE_CYCLES)
        begin
            @(negedge clk);
            if (debug_wb_rf_we != '0)
                abort_run($sformatf("unexpected writeback at pc %h after the last commit",
                                    debug_wb_pc));
        end

        if (st_seen != st_addr.size())
            abort_run($sformatf("only %0d of %0d stores were seen", st_seen, st_addr.size()));
        else
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule
